//--- rtl/qla_macros.svh
// shared constants for the four-axis current command block
// axis count, bus widths, register offsets, safety check limits

`ifndef QLA_MACROS_SVH
`define QLA_MACROS_SVH

`define QLA_NUM_AXES      4        // fixed by the address map
`define QLA_ADDR_W        8        // [7:4] channel, [3:0] offset
`define QLA_DATA_W        32
`define QLA_CUR_W         16       // offset binary
`define QLA_CUR_ZERO      16'h8000 // zero current

// per-axis offsets, channels 1..4
`define QLA_OFF_ADC_DATA  0        // feedback, read only
`define QLA_OFF_DAC_CTRL  1        // command, read/write
// global offsets, channel 0
`define QLA_OFF_STATUS    0        // status read, flag clear write
`define QLA_OFF_DAC_LOAD  1        // start DAC transfer

`define QLA_SAFETY_MARGIN 256      // counts added to 2x command
`define QLA_SAFETY_HOLD   8        // consecutive cycles before trip

`endif

//--- rtl/qla_pkg.sv
// types for the axis command block
// vector typedefs for bus and current words, DAC serializer states

`include "qla_macros.svh"

package qla_pkg;

    typedef logic [`QLA_CUR_W-1:0]  cur_word_t;  // command or feedback
    typedef logic [`QLA_DATA_W-1:0] bus_word_t;
    typedef logic [`QLA_ADDR_W-1:0] bus_addr_t;

    // address fields
    typedef logic [3:0] chan_idx_t;  // 0 = global, 1..4 = axis
    typedef logic [3:0] reg_off_t;

    // DAC serializer FSM
    typedef enum logic [1:0] {
        DAC_IDLE,    // waiting for load
        DAC_SELECT,  // pull csel low, present msb
        DAC_SHIFT,   // clock out 16 bits
        DAC_GAP      // csel high between words
    } dac_state_t;

endpackage

//--- rtl/axis_bus_if.sv
// per-axis register bus
// decoder drives writes and clear, channel returns read word, command, flag

`timescale 1ns/1ps

interface axis_bus_if;
    import qla_pkg::*;

    logic      wen;       // write strobe, one cycle
    reg_off_t  offset;    // register offset, reads and writes
    bus_word_t wdata;
    logic      clear;     // drop sticky disable
    bus_word_t rdata;     // read word selected by offset
    cur_word_t cur_cmd;   // current command register
    logic      disabled;  // safety trip flag

    modport decoder (
        output wen, offset, wdata, clear,
        input  rdata, disabled
    );

    modport channel (
        input  wen, offset, wdata, clear,
        output rdata, cur_cmd, disabled
    );

    // serializer only needs the command
    modport dac (
        input  cur_cmd
    );

endinterface

//--- rtl/wb_reg_decoder.sv
// wishbone classic slave for the axis registers
// ack generation, address split, per-axis write strobes, channel 0 status/load,
// read mux

`timescale 1ns/1ps
`include "qla_macros.svh"

module wb_reg_decoder (
    input  logic               sysclk,
    input  logic               reset,
    // wishbone classic
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  qla_pkg::bus_addr_t wb_adr,
    input  qla_pkg::bus_word_t wb_wdata,
    output qla_pkg::bus_word_t wb_rdata,
    output logic               wb_ack,
    // axis registers
    axis_bus_if.decoder        axes [`QLA_NUM_AXES],
    // DAC serializer
    output logic               load_req,
    input  logic               busy
);
    import qla_pkg::*;

    chan_idx_t adr_chan;
    reg_off_t  adr_off;
    logic      req_start;    // first cycle of a request
    logic      wr_stb;       // write takes effect at this edge
    logic      status_wr;
    bus_word_t axis_rdata [`QLA_NUM_AXES];
    logic [`QLA_NUM_AXES-1:0] dis_flags;
    bus_word_t status_word;
    bus_word_t rd_word;

    assign adr_chan = wb_adr[7:4];
    assign adr_off  = wb_adr[3:0];

    assign req_start = wb_cyc && wb_stb && !wb_ack;  // ack low blocks a second strobe
    assign wr_stb    = req_start && wb_we;

    // channel 0 writes
    assign status_wr = wr_stb && (adr_chan == '0) && (adr_off == reg_off_t'(`QLA_OFF_STATUS));
    assign load_req  = wr_stb && (adr_chan == '0) && (adr_off == reg_off_t'(`QLA_OFF_DAC_LOAD));

    // --------------------
    // per-axis fan out
    // --------------------
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_axis
        assign axes[i].wen    = wr_stb && (adr_chan == chan_idx_t'(i + 1));
        assign axes[i].offset = adr_off;
        assign axes[i].wdata  = wb_wdata;
        assign axes[i].clear  = status_wr && wb_wdata[i];  // bit n-1 clears axis n
        assign axis_rdata[i]  = axes[i].rdata;
        assign dis_flags[i]   = axes[i].disabled;
    end

    // busy in bit 8, trip flags in 3..0
    assign status_word = {23'd0, busy, 4'd0, dis_flags};

    // --------------------
    // read mux
    // --------------------
    always_comb begin
        rd_word = '0;  // unmapped reads give zero
        if (adr_chan == '0) begin
            if (adr_off == reg_off_t'(`QLA_OFF_STATUS)) begin
                rd_word = status_word;
            end
        end else begin
            for (int k = 0; k < `QLA_NUM_AXES; k++) begin
                if (adr_chan == chan_idx_t'(k + 1)) begin
                    rd_word = axis_rdata[k];
                end
            end
        end
    end

    // single-cycle registered ack
    always_ff @(posedge sysclk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req_start;
        end
    end

    // read word held with ack
    always_ff @(posedge sysclk) begin
        if (req_start) begin
            wb_rdata <= rd_word;
        end
    end

endmodule

//--- rtl/axis_channel.sv
// one motor axis
// command register, register read word, feedback vs command safety check

`timescale 1ns/1ps
`include "qla_macros.svh"

module axis_channel (
    input  logic               sysclk,
    input  logic               reset,
    axis_bus_if.channel        bus,
    input  qla_pkg::cur_word_t cur_fb   // from ADC
);
    import qla_pkg::*;

    localparam int CNT_W = $clog2(`QLA_SAFETY_HOLD);
    localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(`QLA_SAFETY_HOLD - 1);

    cur_word_t              cmd_mag;    // |cmd - zero|
    cur_word_t              fb_mag;     // |fb - zero|
    logic [`QLA_CUR_W+1:0]  limit;      // 2*cmd_mag + margin, 18 bits
    logic                   excess;
    logic [CNT_W-1:0]       run_cnt;    // consecutive excess cycles

    // --------------------
    // command register
    // --------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            bus.cur_cmd <= `QLA_CUR_ZERO;   // zero current
        end else if (bus.wen && (bus.offset == reg_off_t'(`QLA_OFF_DAC_CTRL))) begin
            bus.cur_cmd <= bus.wdata[`QLA_CUR_W-1:0];
        end
    end

    // read word by offset, zero extended
    always_comb begin
        case (bus.offset)
            reg_off_t'(`QLA_OFF_ADC_DATA): bus.rdata = bus_word_t'(cur_fb);
            reg_off_t'(`QLA_OFF_DAC_CTRL): bus.rdata = bus_word_t'(bus.cur_cmd);
            default:                       bus.rdata = '0;
        endcase
    end

    // --------------------
    // safety check
    // --------------------
    // magnitudes about mid-scale, offset binary
    assign cmd_mag = (bus.cur_cmd >= `QLA_CUR_ZERO) ? (bus.cur_cmd - `QLA_CUR_ZERO)
                                                    : (`QLA_CUR_ZERO - bus.cur_cmd);
    assign fb_mag  = (cur_fb >= `QLA_CUR_ZERO) ? (cur_fb - `QLA_CUR_ZERO)
                                               : (`QLA_CUR_ZERO - cur_fb);

    assign limit  = {1'b0, cmd_mag, 1'b0} + (`QLA_CUR_W+2)'(`QLA_SAFETY_MARGIN);
    assign excess = {2'b00, fb_mag} > limit;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            run_cnt      <= '0;
            bus.disabled <= 1'b0;
        end else if (bus.clear) begin   // clear wins, run restarts
            run_cnt      <= '0;
            bus.disabled <= 1'b0;
        end else if (excess) begin
            if (run_cnt == HOLD_LAST) begin
                bus.disabled <= 1'b1;   // sticky until cleared
            end else begin
                run_cnt <= run_cnt + 1'b1;
            end
        end else begin
            run_cnt <= '0;              // run broken
        end
    end

endmodule

//--- rtl/dac_serializer.sv
// serial DAC driver for the four axis commands
// load snapshot, single pending request, msb-first shift in csel frames

`timescale 1ns/1ps
`include "qla_macros.svh"

module dac_serializer (
    input  logic        sysclk,
    input  logic        reset,
    axis_bus_if.dac     axes [`QLA_NUM_AXES],
    input  logic        load_req,   // one-cycle pulse
    output logic        busy,
    output logic        dac_sclk,
    output logic        dac_mosi,
    output logic        dac_csel    // active low
);
    import qla_pkg::*;

    localparam int AXIS_W = $clog2(`QLA_NUM_AXES);
    localparam int BIT_W  = $clog2(`QLA_CUR_W);
    localparam logic [AXIS_W-1:0] LAST_AXIS = AXIS_W'(`QLA_NUM_AXES - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(`QLA_CUR_W - 1);

    dac_state_t        state;
    logic              pending;     // load seen while busy
    logic              start;
    cur_word_t         cmd_now  [`QLA_NUM_AXES];
    cur_word_t         snapshot [`QLA_NUM_AXES];
    cur_word_t         shreg;
    logic [AXIS_W-1:0] axis_cnt;
    logic [BIT_W-1:0]  bit_cnt;

    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_cmd
        assign cmd_now[i] = axes[i].cur_cmd;
    end

    assign start = (state == DAC_IDLE) && (load_req || pending);
    assign busy  = (state != DAC_IDLE) || pending;

    // extra requests while busy merge into one
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (start) begin
            pending <= 1'b0;
        end else if (load_req) begin
            pending <= 1'b1;
        end
    end

    // --------------------
    // frame FSM
    // --------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            state    <= DAC_IDLE;
            axis_cnt <= '0;
            bit_cnt  <= '0;
            dac_sclk <= 1'b0;
            dac_mosi <= 1'b0;
            dac_csel <= 1'b1;
        end else begin
            case (state)
                DAC_IDLE: begin
                    if (start) begin
                        axis_cnt <= '0;
                        state    <= DAC_SELECT;
                    end
                end
                DAC_SELECT: begin
                    dac_csel <= 1'b0;
                    dac_sclk <= 1'b0;
                    dac_mosi <= snapshot[axis_cnt][`QLA_CUR_W-1];  // msb first
                    bit_cnt  <= '0;
                    state    <= DAC_SHIFT;
                end
                DAC_SHIFT: begin
                    dac_sclk <= ~dac_sclk;  // sysclk / 2
                    if (dac_sclk) begin     // falling edge, next bit
                        if (bit_cnt == LAST_BIT) begin
                            dac_csel <= 1'b1;
                            state    <= DAC_GAP;
                        end else begin
                            dac_mosi <= shreg[`QLA_CUR_W-2];
                            bit_cnt  <= bit_cnt + 1'b1;
                        end
                    end
                end
                DAC_GAP: begin              // csel high here and in SELECT
                    if (axis_cnt == LAST_AXIS) begin
                        state <= DAC_IDLE;
                    end else begin
                        axis_cnt <= axis_cnt + 1'b1;
                        state    <= DAC_SELECT;
                    end
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

    // snapshot and shift data
    always_ff @(posedge sysclk) begin
        if (start) begin
            snapshot <= cmd_now;
        end
        if (state == DAC_SELECT) begin
            shreg <= snapshot[axis_cnt];
        end else if ((state == DAC_SHIFT) && dac_sclk) begin
            shreg <= {shreg[`QLA_CUR_W-2:0], 1'b0};
        end
    end

endmodule

//--- rtl/qla_axis_top.sv
// top level of the four-axis current command block
// wishbone decoder, four axis channels, DAC serializer

`timescale 1ns/1ps
`include "qla_macros.svh"

module qla_axis_top (
    input  logic                                      sysclk,
    input  logic                                      reset,
    // wishbone classic slave
    input  logic                                      wb_cyc,
    input  logic                                      wb_stb,
    input  logic                                      wb_we,
    input  qla_pkg::bus_addr_t                        wb_adr,
    input  qla_pkg::bus_word_t                        wb_wdata,
    output qla_pkg::bus_word_t                        wb_rdata,
    output logic                                      wb_ack,
    // ADC feedback, [0] is axis 1
    input  qla_pkg::cur_word_t [`QLA_NUM_AXES-1:0]    cur_fb,
    output logic [`QLA_NUM_AXES-1:0]                  amp_disable,
    // serial DAC
    output logic                                      dac_sclk,
    output logic                                      dac_mosi,
    output logic                                      dac_csel
);

    logic load_req;  // decoder to serializer
    logic busy;

    axis_bus_if axes [`QLA_NUM_AXES] ();

    wb_reg_decoder wb_reg_decoder_inst (
        .sysclk   (sysclk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .axes     (axes),
        .load_req (load_req),
        .busy     (busy)
    );

    // --------------------
    // axis channels
    // --------------------
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_chan
        axis_channel axis_channel_inst (
            .sysclk (sysclk),
            .reset  (reset),
            .bus    (axes[i]),
            .cur_fb (cur_fb[i])
        );
        assign amp_disable[i] = axes[i].disabled;  // trip flag to amp
    end

    dac_serializer dac_serializer_inst (
        .sysclk   (sysclk),
        .reset    (reset),
        .axes     (axes),
        .load_req (load_req),
        .busy     (busy),
        .dac_sclk (dac_sclk),
        .dac_mosi (dac_mosi),
        .dac_csel (dac_csel)
    );

endmodule

//--- verification/tb_qla_axis_top.sv
// testbench for the four-axis current command block
// pattern player, wishbone bus tasks, DAC word capture, checks, timeout

`timescale 1ns/1ps
`include "qla_macros.svh"

module tb_qla_axis_top;
    import qla_pkg::*;

    localparam int MAX_REC        = 64;   // pattern memory depth in records
    localparam int CYCLES_PER_REC = 300;

    logic                          sysclk;
    logic                          reset;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    bus_addr_t                     wb_adr;
    bus_word_t                     wb_wdata;
    bus_word_t                     wb_rdata;
    logic                          wb_ack;
    cur_word_t [`QLA_NUM_AXES-1:0] cur_fb;
    logic [`QLA_NUM_AXES-1:0]      amp_disable;
    logic                          dac_sclk;
    logic                          dac_mosi;
    logic                          dac_csel;

    bus_word_t   pat_mem [3*MAX_REC];     // kind, address, value per record
    logic [31:0] lfsr        = 32'hb5ab_a937;
    int          cycle_limit = 0;
    int          cycle_count = 0;
    cur_word_t   frame_shift;
    int          frame_bits  = 0;
    cur_word_t   frames [$];              // completed DAC words in arrival order

    qla_axis_top qla_axis_top_inst (
        .sysclk      (sysclk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_wdata    (wb_wdata),
        .wb_rdata    (wb_rdata),
        .wb_ack      (wb_ack),
        .cur_fb      (cur_fb),
        .amp_disable (amp_disable),
        .dac_sclk    (dac_sclk),
        .dac_mosi    (dac_mosi),
        .dac_csel    (dac_csel)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;  // 20 ns
    end

    // --------------------
    // DAC capture
    // --------------------
    always @(posedge dac_sclk) begin
        if (!dac_csel) begin
            frame_shift = {frame_shift[`QLA_CUR_W-2:0], dac_mosi};  // msb first
            frame_bits++;
            if (frame_bits == `QLA_CUR_W) begin
                frames.push_back(frame_shift);
                frame_bits = 0;
            end
        end
    end

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // 0..3 idle cycles from two lfsr bits
    task automatic idle_gap();
        int n;
        n = 0;
        repeat (2) begin
            n    = n * 2 + int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        repeat (n) @(posedge sysclk);
    endtask

    task automatic check_value(input bus_word_t actual, input bus_word_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // one wishbone classic cycle that returns 2 ns after the ack edge
    task automatic bus_access(input logic we, input bus_addr_t adr, input bus_word_t data,
                              output bus_word_t rdata);
        idle_gap();
        @(posedge sysclk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = data;
        @(posedge sysclk);
        #1;
        while (!wb_ack) begin
            @(posedge sysclk);
            #1;
        end
        rdata = wb_rdata;  // valid with ack
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // --------------------
    // timeout
    // --------------------
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge sysclk);
            cycle_count++;
        end
        $display("the simulation timed out after %0d cycles", cycle_limit);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    // --------------------
    // pattern player
    // --------------------
    initial begin
        int        nrec;
        int        ax;
        bus_word_t kind;
        bus_word_t addr;
        bus_word_t val;
        bus_word_t rd;

        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdata = '0;
        cur_fb   = {`QLA_NUM_AXES{`QLA_CUR_ZERO}};  // zero current on all axes

        $readmemh("verification/qla_patterns.hex", pat_mem);
        nrec = 0;
        while (nrec < MAX_REC && pat_mem[3*nrec] inside {[1:6]}) begin
            nrec++;  // kind 0 ends the list
        end
        if (nrec == 0) begin
            $display("no pattern records could be loaded from the pattern file");
            $display("Simulation failed");
            $fatal(1, "no stimulus");
        end
        cycle_limit = nrec * CYCLES_PER_REC;

        repeat (5) @(posedge sysclk);
        #2;
        reset = 1'b0;

        for (int i = 0; i < nrec; i++) begin
            kind = pat_mem[3*i];
            addr = pat_mem[3*i+1];
            val  = pat_mem[3*i+2];
            case (kind)
                1: bus_access(1'b1, addr[7:0], val, rd);
                2: begin
                    bus_access(1'b0, addr[7:0], 32'h0, rd);
                    check_value(rd, val, $sformatf("read of address %02h", addr[7:0]));
                end
                3: begin                    // axis number 1..4
                    ax = int'(addr) - 1;
                    @(posedge sysclk);
                    #2;
                    cur_fb[ax] = val[`QLA_CUR_W-1:0];
                end
                4: begin
                    repeat (val) @(posedge sysclk);
                    #1;                     // off the edge for later checks
                end
                5: begin
                    while (frames.size() == 0) begin
                        @(posedge sysclk);
                        #1;
                    end
                    check_value(32'(frames.pop_front()), val,
                                $sformatf("DAC word for axis %0d", addr));
                end
                default: check_value(32'(amp_disable), val, "amp_disable flags");
            endcase
        end

        // no DAC words beyond the expected frames
        check_value(32'(frames.size()), 32'h0, "count of DAC words left over");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/qla_pkg.sv
rtl/axis_bus_if.sv
rtl/wb_reg_decoder.sv
rtl/axis_channel.sv
rtl/dac_serializer.sv
rtl/qla_axis_top.sv
verification/tb_qla_axis_top.sv

//--- Makefile
# Verilator build, run and lint for the axis current command block
# override any variable on the command line, e.g. make LOG=run1.log

VERILATOR ?= verilator
TB_TOP    ?= tb_qla_axis_top
DUT_TOP   ?= qla_axis_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TB_TOP)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/qla_patterns.hex
// columns: kind address value, all hex, one record per line
// kind 1 write, 2 read+compare, 3 feedback of axis, 4 wait, 5 DAC word of axis, 6 amp_disable, 0 end
// after reset
2 11 00008000
2 21 00008000
2 31 00008000
2 41 00008000
2 00 00000000
6 00 00000000
// commands, channel 5 ignored
1 11 dead1111
1 21 00002222
1 31 ffff3333
1 41 00004444
1 51 00005555
2 11 00001111
2 21 00002222
2 31 00003333
2 41 00004444
// feedback readback
3 01 00008123
2 10 00008123
3 02 00007f00
2 20 00007f00
// load, then a second load during the transfer
1 01 00000000
1 11 00009999
1 01 00000000
5 01 00001111
5 02 00002222
5 03 00003333
5 04 00004444
5 01 00009999
5 02 00002222
5 03 00003333
5 04 00004444
// safety trip on axis 3, axis 4 right at the limit
1 31 00008000
1 41 00008000
3 04 00008100
3 03 00008400
4 00 00000020
6 00 00000004
2 00 00000004
// clear, then trip again
1 00 00000004
6 00 00000000
4 00 00000020
6 00 00000004
2 00 00000004
0 00 00000000
